/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_tb
FLIST     = flist.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir

/* flist.f */
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/insn_mem.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
test/fetch_checker.sv
test/fetch_monitor.sv
test/fetch_tb.sv

/* test/fetch_checker.sv */
// Concurrent assertions on the fetch stage save, exception flags and stall, attached with bind
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
	input logic            clk,
	input logic            rst_i,
	input logic            save_i,
	input logic            saved_i,
	input logic            ack_i,
	input logic            stall_i,
	input logic            flush_i,
	input logic [XLEN-1:0] addr_i,
	input logic [2:0]      flags_i
);

	// Saved flag follows a save by one cycle
	save_sets_saved: assert property (@(posedge clk) disable iff (rst_i) save_i |=> saved_i)
		else $error("Saved state not set one cycle after a save");

	// Exception flags are exclusive
	one_flag_max: assert property (@(posedge clk) disable iff (rst_i) $onehot0(flags_i))
		else $error("More than one exception flag high");

	// Stalled word is asked for again, so the next ack is for the same address
	stall_holds_addr: assert property (@(posedge clk) disable iff (rst_i)
		stall_i && !flush_i |=> !ack_i || $stable(addr_i))
		else $error("Ack after a stall returned a different address");

endmodule

bind fetch_stage fetch_checker u_checker (
	.clk     (clk),
	.rst_i   (rst_i),
	.save_i  (save),
	.saved_i (saved_q),
	.ack_i   (ack_i),
	.stall_i (stall_o),
	.flush_i (flush_i),
	.addr_i  (addr_i),
	.flags_i ({except_buserr_o, except_protfault_o, except_tlbmiss_o})
);

/* test/fetch_monitor.sv */
// Delivery monitor comparing fetched PC, instruction and flags with the expected entry
`timescale 1ns/1ps

module fetch_monitor import fetch_pkg::*; (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            freeze_i,
	input  logic            stall_i,
	input  logic [XLEN-1:0] insn_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [2:0]      flags_i,
	input  logic [XLEN-1:0] exp_pc_i,
	input  logic [XLEN-1:0] exp_insn_i,
	input  logic [2:0]      exp_flags_i,
	input  logic [3:0]      exp_test_i,
	input  int              n_exp_i,
	output int              count_o,
	output int              errors_o
);

	// Readable name for the test id column
	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "sequential";
			4'd2:    return "flush";
			4'd3:    return "squash";
			4'd4:    return "fault";
			default: return "unknown";
		endcase
	endfunction

	// Outputs settle at posedge, so look at negedge
	always @(negedge clk) begin
		if (rst_i) begin
			count_o  <= 0;
			errors_o <= 0;
		end else if (!freeze_i && !stall_i && (insn_i != NOP_FLUSH || flags_i != 3'b000)) begin
			// Bubbles without a flag are not deliveries
			if (count_o >= n_exp_i) begin
				$display("Unexpected delivery at pc %h after the last expected one", pc_i);
				errors_o <= errors_o + 1;
			end else if (pc_i !== exp_pc_i || insn_i !== exp_insn_i || flags_i !== exp_flags_i) begin
				$display("Mismatch %s delivery %0d: expected pc %h insn %h flags %b, %s %h %h %b",
					test_name(exp_test_i), count_o, exp_pc_i, exp_insn_i, exp_flags_i,
					"actual pc insn flags", pc_i, insn_i, flags_i);
				errors_o <= errors_o + 1;
			end
			count_o <= count_o + 1;
		end
	end

endmodule

/* test/fetch_tb.sv */
// Fetch front end testbench with clock, reset, vector load, random stimulus, watchdog and report
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	// Vector file layout, word offsets
	localparam int IMG_BASE = 8;
	localparam int SCR_BASE = 32;
	localparam int EXP_BASE = 64;

	logic            clk;
	logic            rst_i;
	logic            freeze_i;
	logic            flush_i;
	logic [XLEN-1:0] flush_target_i;
	logic            squash_i;
	logic            mem_wait_i;
	logic            load_en_i;
	logic [XLEN-1:0] load_addr_i;
	logic [XLEN-1:0] load_data_i;
	logic [XLEN-1:0] insn_o;
	logic [XLEN-1:0] pc_o;
	logic            if_stall_o;
	logic            except_tlbmiss_o;
	logic            except_protfault_o;
	logic            except_buserr_o;

	// Raw vectors and unpacked lists
	logic [XLEN-1:0] vec [256];
	logic [XLEN-1:0] img_q [$];
	int              scr_kind_q [$];
	int              scr_cnt_q [$];
	logic [XLEN-1:0] scr_tgt_q [$];
	logic [XLEN-1:0] exp_pc_q [$];
	logic [XLEN-1:0] exp_insn_q [$];
	logic [2:0]      exp_flags_q [$];
	logic [3:0]      exp_test_q [$];
	int              n_img;
	int              n_scr;
	int              n_exp;
	int              limit;

	// Monitor side
	int              cnt;
	int              errs;
	logic [XLEN-1:0] exp_pc;
	logic [XLEN-1:0] exp_insn;
	logic [2:0]      exp_flags;
	logic [3:0]      exp_test;

	fetch_top i_dut (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.flush_target_i     (flush_target_i),
		.squash_i           (squash_i),
		.mem_wait_i         (mem_wait_i),
		.load_en_i          (load_en_i),
		.load_addr_i        (load_addr_i),
		.load_data_i        (load_data_i),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.if_stall_o         (if_stall_o),
		.except_tlbmiss_o   (except_tlbmiss_o),
		.except_protfault_o (except_protfault_o),
		.except_buserr_o    (except_buserr_o)
	);

	// Entry the next delivery is held against
	assign exp_pc    = (cnt < n_exp) ? exp_pc_q[cnt] : '0;
	assign exp_insn  = (cnt < n_exp) ? exp_insn_q[cnt] : '0;
	assign exp_flags = (cnt < n_exp) ? exp_flags_q[cnt] : '0;
	assign exp_test  = (cnt < n_exp) ? exp_test_q[cnt] : '0;

	fetch_monitor u_monitor (
		.clk         (clk),
		.rst_i       (rst_i),
		.freeze_i    (freeze_i),
		.stall_i     (if_stall_o),
		.insn_i      (insn_o),
		.pc_i        (pc_o),
		.flags_i     ({except_buserr_o, except_protfault_o, except_tlbmiss_o}),
		.exp_pc_i    (exp_pc),
		.exp_insn_i  (exp_insn),
		.exp_flags_i (exp_flags),
		.exp_test_i  (exp_test),
		.n_exp_i     (n_exp),
		.count_o     (cnt),
		.errors_o    (errs)
	);

	////////////////////
	// Clock and reset
	////////////////////

	initial clk = 1'b0;
	always #4 clk = ~clk;

	initial begin
		rst_i = 1'b1;
		repeat (10) @(posedge clk);
		rst_i <= 1'b0;
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int  sidx;
		logic taken;
		void'($urandom(33202));
		freeze_i       = 1'b0;
		flush_i        = 1'b0;
		flush_target_i = '0;
		squash_i       = 1'b0;
		// Memory held off until the image is in
		mem_wait_i     = 1'b1;
		load_en_i      = 1'b0;
		load_addr_i    = '0;
		load_data_i    = '0;
		n_exp          = 0;
		limit          = 0;
		$readmemh("test/fetch_vectors.txt", vec);
		n_img = int'(vec[0]);
		n_scr = int'(vec[1]);
		for (int i = 0; i < n_img; i++) begin
			img_q.push_back(vec[8'(IMG_BASE + i)]);
		end
		for (int i = 0; i < n_scr; i++) begin
			scr_kind_q.push_back(int'(vec[8'(SCR_BASE + 3*i)]));
			scr_cnt_q.push_back(int'(vec[8'(SCR_BASE + 3*i + 1)]));
			scr_tgt_q.push_back(vec[8'(SCR_BASE + 3*i + 2)]);
		end
		for (int i = 0; i < int'(vec[2]); i++) begin
			exp_pc_q.push_back(vec[8'(EXP_BASE + 4*i)]);
			exp_insn_q.push_back(vec[8'(EXP_BASE + 4*i + 1)]);
			exp_flags_q.push_back(vec[8'(EXP_BASE + 4*i + 2)][2:0]);
			exp_test_q.push_back(vec[8'(EXP_BASE + 4*i + 3)][3:0]);
		end
		n_exp = int'(vec[2]);
		limit = 40*n_exp + n_img + 10;

		// Image load starts inside reset
		for (int i = 0; i < n_img; i++) begin
			@(posedge clk);
			load_en_i   <= 1'b1;
			load_addr_i <= XLEN'(4*i);
			load_data_i <= img_q[i];
		end
		@(posedge clk);
		load_en_i <= 1'b0;
		wait (!rst_i);

		// Random freezes and waits, scripted flush and squash
		sidx = 0;
		while (cnt < n_exp) begin
			@(negedge clk);
			// Squash is done once its slot was consumed
			taken = squash_i && !freeze_i && !if_stall_o;
			@(posedge clk);
			flush_i <= 1'b0;
			if (taken) begin
				squash_i <= 1'b0;
			end
			if (sidx < n_scr && cnt == scr_cnt_q[sidx]) begin
				if (scr_kind_q[sidx] == 1) begin
					flush_i        <= 1'b1;
					flush_target_i <= scr_tgt_q[sidx];
				end else begin
					squash_i <= 1'b1;
				end
				sidx++;
			end
			if (cnt < n_exp) begin
				freeze_i   <= ($urandom_range(3) == 0);
				mem_wait_i <= ($urandom_range(3) == 0);
			end else begin
				// Last entry is in, hold decode so nothing follows it
				freeze_i <= 1'b1;
			end
		end

		repeat (2) @(posedge clk);
		$display("Errors: %0d mismatches, 0 timeouts", errs);
		if (errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	////////////////////
	// Watchdog
	////////////////////

	initial begin
		wait (limit > 0);
		repeat (limit) @(posedge clk);
		$display("Timeout: only %0d of %0d expected deliveries arrived", cnt, n_exp);
		$display("Errors: %0d mismatches, 1 timeouts", errs);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* test/fetch_vectors.txt */
// Header: image words, script entries, expected deliveries (all numbers hex)
@0
18 6 f
// Memory image from word 0 up, eight words per line
@8
3c000000 3c040004 3c080008 3c0c000c 3c100010 3c140014 3c180018 3c1c001c
3c200020 3c240024 3c280028 3c2c002c 3c300030 3c340034 3c380038 3c3c003c
3c400040 3c440044 3c480048 3c4c004c 3c500050 3c540054 3c580058 3c5c005c
// Script: kind (1 flush, 2 squash), delivery count, flush target
@20
1 6 40
2 8 0
1 9 c4
1 a 100
1 b 80000000
1 c 18
// Expected: pc, insn, flags {buserr protfault tlbmiss}, test (1 seq 2 flush 3 squash 4 fault)
@40
0 3c000000 0 1
4 3c040004 0 1
8 3c080008 0 1
c 3c0c000c 0 1
10 3c100010 0 1
14 3c140014 0 1
40 3c400040 0 2
44 3c440044 0 2
4c 3c4c004c 0 3
c4 14410000 2 4
100 14410000 4 4
80000000 14410000 1 4
18 3c180018 0 2
1c 3c1c001c 0 2
20 3c200020 0 2

/* verilog/fetch_pkg.sv */
// Shared fetch widths, NOP encodings, memory error tags and reset address
package fetch_pkg;

	////////////////////
	// Widths
	////////////////////

	// Data and address width, one word
	localparam int XLEN = 32;

	// Memory error tag width
	localparam int TAG_W = 4;

	////////////////////
	// Error tag codes
	////////////////////

	// Translation miss
	localparam logic [TAG_W-1:0] ITAG_TE = 4'hd;
	// Protection fault
	localparam logic [TAG_W-1:0] ITAG_PE = 4'hc;
	// Bus error
	localparam logic [TAG_W-1:0] ITAG_BE = 4'hb;

	////////////////////
	// NOP encodings
	////////////////////

	// Major opcode of the NOP
	localparam logic [5:0] NOP_OPC = 6'b000101;

	// Bubble for flush, squash and bypass
	localparam logic [XLEN-1:0] NOP_FLUSH = {NOP_OPC, 26'h0410000};

	// Shown while waiting on memory
	localparam logic [XLEN-1:0] NOP_STALL = {NOP_OPC, 26'h0610000};

	// First fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

endpackage

/* verilog/fetch_stage.sv */
// Fetch stage with instruction save, flush bypass, bubble insertion and exception decode
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             ack_i,
	input  logic             err_i,
	input  logic [XLEN-1:0]  data_i,
	input  logic [XLEN-1:0]  addr_i,
	input  logic             first_i,
	input  logic [TAG_W-1:0] tag_i,
	input  logic             freeze_i,
	input  logic             flush_i,
	input  logic             squash_i,
	output logic [XLEN-1:0]  insn_o,
	output logic [XLEN-1:0]  pc_o,
	output logic             stall_o,
	output logic             refetch_o,
	output logic             except_tlbmiss_o,
	output logic             except_protfault_o,
	output logic             except_buserr_o
);

	logic            resp;
	logic            bypass;
	logic            bypass_q;
	logic            kill;
	logic            save;
	logic            saved_q;
	logic [XLEN-1:0] insn_saved;
	logic [XLEN-1:0] addr_saved;
	// Flags ordered bus error, protection, translation
	logic [2:0]      err_now;
	logic [2:0]      err_saved;
	logic [2:0]      err_out;

	// Any response this cycle
	assign resp = ack_i || err_i;

	////////////////////
	// Flush bypass
	////////////////////

	// Stale responses dropped until the redirected one shows up
	assign bypass = flush_i || (bypass_q && !(resp && first_i));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= bypass;
		end
	end

	// Slot becomes a bubble
	assign kill = squash_i || bypass;

	////////////////////
	// Save register
	////////////////////

	// Only the first live response of a freeze is kept
	assign save = resp && freeze_i && !saved_q && !bypass;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			// Shown for the last time this cycle
			saved_q <= 1'b0;
		end
	end

	// Payload, qualified by saved_q
	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved <= err_i ? NOP_FLUSH : data_i;
			addr_saved <= {addr_i[XLEN-1:2], 2'b00};
			err_saved  <= err_now;
		end
	end

	////////////////////
	// Exception decode
	////////////////////

	assign err_now[0] = err_i && (tag_i == ITAG_TE);
	assign err_now[1] = err_i && (tag_i == ITAG_PE);
	assign err_now[2] = err_i && (tag_i == ITAG_BE);

	// Bubbles carry no flags, stale faults included
	assign err_out = kill ? 3'b000 : (saved_q ? err_saved : err_now);

	assign except_tlbmiss_o   = err_out[0];
	assign except_protfault_o = err_out[1];
	assign except_buserr_o    = err_out[2];

	////////////////////
	// Decode side
	////////////////////

	// Saved word beats anything newer
	always_comb begin
		if (kill) begin
			insn_o = NOP_FLUSH;
		end else if (saved_q) begin
			insn_o = insn_saved;
		end else if (ack_i) begin
			insn_o = data_i;
		end else if (err_i) begin
			insn_o = NOP_FLUSH;
		end else begin
			insn_o = NOP_STALL;
		end
	end

	assign pc_o    = saved_q ? addr_saved : {addr_i[XLEN-1:2], 2'b00};
	assign stall_o = !resp && !saved_q;

	// New ack for another word is lost behind the saved one
	assign refetch_o = saved_q && ack_i && (addr_i[XLEN-1:2] != addr_saved[XLEN-1:2]);

endmodule

/* verilog/fetch_top.sv */
// Fetch front end top level with PC generator, instruction memory and fetch stage
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter int unsigned     MEM_WORDS  = 64,
	parameter logic [XLEN-1:0] TLB_BASE   = 32'h8000_0000,
	parameter logic [XLEN-1:0] PROT_BASE  = 32'h0000_00c0,
	parameter logic [XLEN-1:0] PROT_LIMIT = 32'h0000_00ff
) (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            freeze_i,
	input  logic            flush_i,
	input  logic [XLEN-1:0] flush_target_i,
	input  logic            squash_i,
	input  logic            mem_wait_i,
	input  logic            load_en_i,
	input  logic [XLEN-1:0] load_addr_i,
	input  logic [XLEN-1:0] load_data_i,
	output logic [XLEN-1:0] insn_o,
	output logic [XLEN-1:0] pc_o,
	output logic            if_stall_o,
	output logic            except_tlbmiss_o,
	output logic            except_protfault_o,
	output logic            except_buserr_o
);

	// Request path
	logic [XLEN-1:0]  req_addr;
	logic             req_first;

	// Response path
	logic             resp_ack;
	logic             resp_err;
	logic [XLEN-1:0]  resp_data;
	logic [XLEN-1:0]  resp_addr;
	logic             resp_first;
	logic [TAG_W-1:0] resp_tag;

	// Back to the PC generator
	logic             genpc_refetch;

	////////////////////
	// PC generator
	////////////////////

	pc_gen u_pc_gen (
		.clk            (clk),
		.rst_i          (rst_i),
		.freeze_i       (freeze_i),
		.stall_i        (if_stall_o),
		.refetch_i      (genpc_refetch),
		.flush_i        (flush_i),
		.flush_target_i (flush_target_i),
		.req_addr_o     (req_addr),
		.req_first_o    (req_first)
	);

	////////////////////
	// Memory
	////////////////////

	insn_mem #(
		.MEM_WORDS  (MEM_WORDS),
		.TLB_BASE   (TLB_BASE),
		.PROT_BASE  (PROT_BASE),
		.PROT_LIMIT (PROT_LIMIT)
	) u_insn_mem (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_addr_i  (req_addr),
		.req_first_i (req_first),
		.wait_i      (mem_wait_i),
		.load_en_i   (load_en_i),
		.load_addr_i (load_addr_i),
		.load_data_i (load_data_i),
		.ack_o       (resp_ack),
		.err_o       (resp_err),
		.data_o      (resp_data),
		.addr_o      (resp_addr),
		.first_o     (resp_first),
		.tag_o       (resp_tag)
	);

	////////////////////
	// Fetch stage
	////////////////////

	fetch_stage u_fetch_stage (
		.clk                (clk),
		.rst_i              (rst_i),
		.ack_i              (resp_ack),
		.err_i              (resp_err),
		.data_i             (resp_data),
		.addr_i             (resp_addr),
		.first_i            (resp_first),
		.tag_i              (resp_tag),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.squash_i           (squash_i),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (if_stall_o),
		.refetch_o          (genpc_refetch),
		.except_tlbmiss_o   (except_tlbmiss_o),
		.except_protfault_o (except_protfault_o),
		.except_buserr_o    (except_buserr_o)
	);

endmodule

/* verilog/insn_mem.sv */
// Instruction memory with load port, wait input and region based fault tags
`timescale 1ns/1ps

module insn_mem import fetch_pkg::*; #(
	parameter int unsigned     MEM_WORDS  = 64,
	parameter logic [XLEN-1:0] TLB_BASE   = 32'h8000_0000,
	parameter logic [XLEN-1:0] PROT_BASE  = 32'h0000_00c0,
	parameter logic [XLEN-1:0] PROT_LIMIT = 32'h0000_00ff
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic [XLEN-1:0]  req_addr_i,
	input  logic             req_first_i,
	input  logic             wait_i,
	input  logic             load_en_i,
	input  logic [XLEN-1:0]  load_addr_i,
	input  logic [XLEN-1:0]  load_data_i,
	output logic             ack_o,
	output logic             err_o,
	output logic [XLEN-1:0]  data_o,
	output logic [XLEN-1:0]  addr_o,
	output logic             first_o,
	output logic [TAG_W-1:0] tag_o
);

	// Word index width
	localparam int AW = $clog2(MEM_WORDS);

	logic [XLEN-1:0]  mem [MEM_WORDS];
	logic             fault;
	logic [TAG_W-1:0] fault_tag;
	logic             load_ok;

	////////////////////
	// Fault regions
	////////////////////

	// First match wins
	always_comb begin
		fault     = 1'b1;
		fault_tag = ITAG_BE;
		if (req_addr_i >= TLB_BASE) begin
			// No translation up there
			fault_tag = ITAG_TE;
		end else if (req_addr_i >= PROT_BASE && req_addr_i <= PROT_LIMIT) begin
			fault_tag = ITAG_PE;
		end else if (req_addr_i[XLEN-1:2] >= (XLEN-2)'(MEM_WORDS)) begin
			// Past the end of the array
			fault_tag = ITAG_BE;
		end else begin
			fault     = 1'b0;
			fault_tag = '0;
		end
	end

	////////////////////
	// Load port
	////////////////////

	// Writes outside the array are dropped
	assign load_ok = load_en_i && (load_addr_i[XLEN-1:2] < (XLEN-2)'(MEM_WORDS));

	always_ff @(posedge clk) begin
		if (load_ok) begin
			mem[load_addr_i[AW+1:2]] <= load_data_i;
		end
	end

	// One strobe per cycle, none while waiting
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			ack_o <= !wait_i && !fault;
			err_o <= !wait_i && fault;
		end
	end

	// Response payload, echoed with the request
	always_ff @(posedge clk) begin
		data_o  <= mem[req_addr_i[AW+1:2]];
		addr_o  <= req_addr_i;
		first_o <= req_first_i;
		tag_o   <= fault_tag;
	end

endmodule

/* verilog/pc_gen.sv */
// Program counter with sequential advance, flush redirect and refetch hold
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            freeze_i,
	input  logic            stall_i,
	input  logic            refetch_i,
	input  logic            flush_i,
	input  logic [XLEN-1:0] flush_target_i,
	output logic [XLEN-1:0] req_addr_o,
	output logic            req_first_o
);

	// Address last handed to memory
	logic [XLEN-1:0] pc_q;
	// Redirect marker still pending
	logic            first_q;
	// Current response consumed this cycle
	logic            advance;

	////////////////////
	// Next request
	////////////////////

	// Move on only when decode takes the word
	assign advance = !freeze_i && !stall_i && !refetch_i;

	// Request is the next PC, so memory sees it one cycle early
	always_comb begin
		if (flush_i) begin
			// Redirect, force word alignment
			req_addr_o = {flush_target_i[XLEN-1:2], 2'b00};
		end else if (advance) begin
			req_addr_o = pc_q + XLEN'(4);
		end else begin
			// Freeze, stall or refetch re-presents the same word
			req_addr_o = pc_q;
		end
	end

	// Marker survives waits and freezes until the target is consumed
	assign req_first_o = flush_i || (first_q && !advance);

	////////////////////
	// State
	////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q    <= RESET_PC;
			// Reset counts as a redirect
			first_q <= 1'b1;
		end else begin
			pc_q    <= req_addr_o;
			first_q <= req_first_o;
		end
	end

endmodule
